//--- design/channelPulser.sv
module channelPulser #(
	parameter int MaxPhaseDelay = 1000
) (
	input  txChanPkg::fireCntT    fireCnt,
	input  logic                  fireRunning,
	input  txChanPkg::phaseDelayT phaseDelay,
	input  txChanPkg::chargeTimeT chargeTime,
	output logic                  pulse,
	output logic                  active,
	output logic                  rangeError
);

	localparam txChanPkg::phaseDelayT DelayLimit = MaxPhaseDelay[15:0];

	txChanPkg::fireCntT windowStart;
	txChanPkg::fireCntT windowEnd;

	// pulse window in shared counter ticks
	assign windowStart = {1'b0, phaseDelay};
	assign windowEnd = windowStart + {8'b0, chargeTime};

	assign active = fireRunning && (fireCnt < windowEnd);
	assign pulse = fireRunning && (fireCnt >= windowStart) && (fireCnt < windowEnd);

	// checked once, on the first counter tick
	assign rangeError = fireRunning && (fireCnt == '0) && (phaseDelay > DelayLimit);

	always_comb
	begin
		if (fireRunning)
		begin
			assert (!pulse || active)
				else $error("pulse outside the active window");
		end
	end

endmodule

//--- design/fireControl.sv
module fireControl #(
	parameter int NumChannels   = 8,
	parameter int MaxPhaseDelay = 1000
) (
	input  logic                                    txCLK,
	input  logic                                    rst,
	input  logic                                    runEnable,
	input  logic                                    clearFault,
	input  logic                                    fireStrobe,
	input  txChanPkg::chargeTimeT                   fireChargeTime,
	input  txChanPkg::phaseDelayT [NumChannels-1:0] phaseDelays,
	input  logic [NumChannels-1:0]                  channelMask,
	output logic [NumChannels-1:0]                  transducerOut,
	output logic [NumChannels-1:0]                  transducerError,
	output logic                                    channelFault
);

	txChanPkg::phaseDelayT [NumChannels-1:0] delayReg; // sampled at fire start
	txChanPkg::chargeTimeT chargeReg;
	txChanPkg::fireCntT fireCnt;
	logic fireRunning;
	logic startFire;
	logic [NumChannels-1:0] pulse;
	logic [NumChannels-1:0] active;
	logic [NumChannels-1:0] rangeError;

	assign channelFault = |transducerError;
	// a fire during a running pulse is dropped
	assign startFire = fireStrobe && runEnable && !fireRunning && !channelFault;

	always_ff @(posedge txCLK)
	begin
		if (startFire)
		begin
			delayReg <= phaseDelays;
			chargeReg <= fireChargeTime;
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			fireRunning <= 1'b0;
			fireCnt <= '0;
			transducerOut <= '0;
			transducerError <= '0;
		end
		else
		begin
			if (clearFault)
				transducerError <= '0;
			else
				transducerError <= transducerError | rangeError; // latched until cleared
			if (startFire)
			begin
				fireRunning <= 1'b1;
				fireCnt <= '0;
			end
			else if (fireRunning)
			begin
				fireCnt <= fireCnt + 1'b1;
				if (!runEnable || (|rangeError) || !(|active))
					fireRunning <= 1'b0;
			end
			if (!runEnable || channelFault || (|rangeError))
				transducerOut <= '0;
			else
				transducerOut <= pulse & channelMask;
		end
	end

	for (genvar i = 0; i < NumChannels; i++)
	begin : gChan
		channelPulser #(
			.MaxPhaseDelay(MaxPhaseDelay)
		) pulser_i (
			.fireCnt    (fireCnt),
			.fireRunning(fireRunning),
			.phaseDelay (delayReg[i]),
			.chargeTime (chargeReg),
			.pulse      (pulse[i]),
			.active     (active[i]),
			.rangeError (rangeError[i])
		);
	end

	// mask applies to the cycle the output was registered from
	assert property (@(posedge txCLK) disable iff (rst)
		(transducerOut & ~$past(channelMask)) == '0)
		else $error("masked channel driven");

endmodule

//--- design/instrExecute.sv
module instrExecute (
	input  logic                   txCLK,
	input  logic                   rst,
	input  logic                   runEnable,
	input  logic                   instrStrobe,
	input  txCmdPkg::instrTypeT    currentType,
	input  txCmdPkg::instrPayloadU currentPayload,
	input  logic                   adcTriggerAck,
	output logic                   trigSetStrobe,
	output logic [6:0]             trigSetValue,
	output logic                   ledSetStrobe,
	output logic [7:0]             ledSetValue,
	output logic                   fireStrobe,
	output txChanPkg::chargeTimeT  fireChargeTime,
	output logic                   adcTriggerLine
);

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			trigSetStrobe <= 1'b0;
			ledSetStrobe <= 1'b0;
			fireStrobe <= 1'b0;
			adcTriggerLine <= 1'b0;
		end
		else
		begin
			trigSetStrobe <= instrStrobe && currentType[txCmdPkg::OpSetTrig];
			ledSetStrobe <= instrStrobe && currentType[txCmdPkg::OpSetLeds];
			fireStrobe <= instrStrobe && currentType[txCmdPkg::OpFire];
			if (!runEnable)
				adcTriggerLine <= 1'b0;
			else if (instrStrobe && currentType[txCmdPkg::OpTriggerRecv])
				adcTriggerLine <= 1'b1;
			else if (adcTriggerLine && adcTriggerAck)
				adcTriggerLine <= 1'b0; // ADC has seen it
		end
	end

	// payload views, picked by opcode downstream
	always_ff @(posedge txCLK)
	begin
		if (instrStrobe)
		begin
			trigSetValue <= currentPayload.trig.trigVals;
			ledSetValue <= currentPayload.led.ledVals;
			if (currentType[txCmdPkg::OpSetChargeTime])
				fireChargeTime <= currentPayload.charge.chargeTime;
			else
				fireChargeTime <= txChanPkg::DefaultChargeTime;
		end
	end

endmodule

//--- design/instrFetch.sv
module instrFetch #(
	parameter int AddrWidth = 13
) (
	input  logic                   txCLK,
	input  logic                   rst,
	input  logic                   runEnable,
	input  logic                   loadEnable,
	input  logic [AddrWidth-1:0]   programStartAddr,
	input  txCmdPkg::instrWordT    instrWord,
	input  logic                   externalTrig,
	output logic [AddrWidth-1:0]   instrReadAddr,
	output logic                   instrStrobe,
	output txCmdPkg::instrTypeT    currentType,
	output txCmdPkg::instrPayloadU currentPayload
);

	localparam txCmdPkg::instrTypeT NoOpType = 16'h1 << txCmdPkg::OpNoOp;

	txCmdPkg::instrDelayT delayCnt; // cycles left before next accept
	logic waitBlocked;
	logic accept;

	// wait-external holds back the instruction after it
	assign waitBlocked = currentType[txCmdPkg::OpWaitExternal] && !externalTrig;
	assign accept = runEnable && (delayCnt == '0) &&
		!currentType[txCmdPkg::OpProgramEnd] && !waitBlocked;

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			instrReadAddr <= '0;
			instrStrobe <= 1'b0;
			delayCnt <= '0;
			currentType <= NoOpType;
		end
		else
		begin
			instrStrobe <= accept;
			if (loadEnable)
			begin
				instrReadAddr <= programStartAddr;
				delayCnt <= '0;
				currentType <= NoOpType;
			end
			else if (runEnable)
			begin
				if (accept)
				begin
					currentType <= instrWord.instrType;
					delayCnt <= instrWord.delay;
					instrReadAddr <= instrReadAddr + 1'b1; // memory answers combinationally
				end
				else if (delayCnt != '0)
					delayCnt <= delayCnt - 1'b1;
			end
			else
			begin
				// parked at zero outside run and load
				instrReadAddr <= '0;
				delayCnt <= '0;
				currentType <= NoOpType;
			end
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (!loadEnable && accept)
			currentPayload <= instrWord.payload;
	end

	// every strobe comes from an accept made while running
	assert property (@(posedge txCLK) disable iff (rst)
		instrStrobe |-> $past(runEnable))
		else $error("instrStrobe without runEnable");

endmodule

//--- design/txChanPkg.sv
package txChanPkg;

	// per channel delay from the shared fire start, in txCLK cycles
	typedef logic [15:0] phaseDelayT;

	// pulse length, common to all channels of one fire
	typedef logic [8:0] chargeTimeT;

	// shared counter, wide enough for the longest delay plus charge time
	typedef logic [16:0] fireCntT;

	// used when a fire carries no set-charge-time bit
	localparam chargeTimeT DefaultChargeTime = 9'd500;

endpackage

//--- design/txCmdPkg.sv
package txCmdPkg;

	// host control command, one mode per code
	typedef logic [7:0] controlCommT;

	localparam controlCommT HardReset        = 8'h00;
	localparam controlCommT SoftReset        = 8'h01;
	localparam controlCommT LoadProgram      = 8'h02;
	localparam controlCommT SetTrigOutput    = 8'h04;
	localparam controlCommT SetTrigRestLevel = 8'h05;
	localparam controlCommT TestTrigOutput   = 8'h06;
	localparam controlCommT SetLedOutput     = 8'h08;
	localparam controlCommT RunProgram       = 8'h80;

	// bit positions in the one-hot instruction type
	localparam int OpNoOp          = 0;
	localparam int OpSetTrig       = 1;
	localparam int OpSetLeds       = 2;
	localparam int OpTriggerRecv   = 3;
	localparam int OpFire          = 7;
	localparam int OpSetChargeTime = 9; // only used alongside OpFire
	localparam int OpWaitExternal  = 11;
	localparam int OpProgramEnd    = 15;

	typedef logic [15:0] instrTypeT;
	typedef logic [31:0] instrDelayT; // cycles until the next instruction

	// payload meaning depends on the opcode bits
	typedef union packed {
		struct packed {
			logic [6:0] trigVals;
			logic [8:0] unused;
		} trig;
		struct packed {
			logic [6:0] unused;
			logic [8:0] chargeTime;
		} charge;
		struct packed {
			logic [7:0] unused;
			logic [7:0] ledVals;
		} led;
	} instrPayloadU;

	typedef struct packed {
		instrTypeT    instrType; // bits 63:48
		instrPayloadU payload;   // bits 47:32
		instrDelayT   delay;     // bits 31:0
	} instrWordT;

endpackage

//--- design/txModeControl.sv
module txModeControl (
	input  logic                  txCLK,
	input  logic                  rst,
	input  txCmdPkg::controlCommT controlComm,
	input  logic [7:0]            ledReg,
	input  logic [7:0]            trigReg,
	input  logic [7:0]            trigRestLevelReg,
	input  logic                  trigSetStrobe,
	input  logic [6:0]            trigSetValue,
	input  logic                  ledSetStrobe,
	input  logic [7:0]            ledSetValue,
	input  logic                  channelFault,
	output logic                  runEnable,
	output logic                  loadEnable,
	output logic                  clearFault,
	output logic [7:0]            triggerOut,
	output logic [7:0]            ledOut
);

	logic [7:0] trigRestLevel;
	logic runFlag;    // run requested, no fault yet
	logic faultSeen;  // sticky for the rest of this run
	logic dangerFlag; // outputs were under program control last cycle
	logic inRun;
	logic inSetMode;

	assign inRun = (controlComm == txCmdPkg::RunProgram);
	assign inSetMode = (controlComm == txCmdPkg::SetTrigOutput) ||
		(controlComm == txCmdPkg::SetTrigRestLevel) ||
		(controlComm == txCmdPkg::SetLedOutput);

	assign runEnable = runFlag && inRun && !channelFault;
	assign loadEnable = (controlComm == txCmdPkg::LoadProgram);
	assign clearFault = !inRun && !inSetMode; // error latch survives run and set modes

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			trigRestLevel <= '0;
			triggerOut <= '0;
			ledOut <= '0;
			runFlag <= 1'b0;
			faultSeen <= 1'b0;
			dangerFlag <= 1'b0;
		end
		else
		begin
			runFlag <= inRun && !faultSeen && !channelFault;
			faultSeen <= inRun && (faultSeen || channelFault);
			dangerFlag <= runEnable;
			if (dangerFlag && !runEnable)
			begin
				// program stopped or faulted
				triggerOut <= trigRestLevel;
				ledOut <= '0;
			end
			else
			begin
				case (controlComm)
					txCmdPkg::HardReset:
					begin
						trigRestLevel <= '0;
						triggerOut <= '0;
						ledOut <= '0;
					end
					txCmdPkg::SetTrigOutput:
						if (!runFlag) triggerOut <= trigReg;
					txCmdPkg::SetTrigRestLevel:
						if (!runFlag) trigRestLevel <= trigRestLevelReg;
					txCmdPkg::TestTrigOutput:
						if (!runFlag) triggerOut <= trigReg ^ trigRestLevel;
					txCmdPkg::SetLedOutput:
						if (!runFlag) ledOut <= ledReg;
					txCmdPkg::RunProgram:
					begin
						if (runEnable && trigSetStrobe)
							triggerOut <= {1'b0, trigSetValue} ^ trigRestLevel;
						if (runEnable && ledSetStrobe)
							ledOut <= ledSetValue;
					end
					default:
					begin
						triggerOut <= trigRestLevel; // soft reset, load, unknown
						ledOut <= '0;
					end
				endcase
			end
		end
	end

	// a fault keeps the program stopped on the following cycle
	assert property (@(posedge txCLK) disable iff (rst)
		channelFault |=> !runEnable)
		else $error("runEnable high after a channel fault");

endmodule

//--- design/txSequencerTop.sv
module txSequencerTop #(
	parameter int NumChannels   = 8,
	parameter int MaxPhaseDelay = 1000,
	parameter int AddrWidth     = 13
) (
	input  logic                                    txCLK,
	input  logic                                    rst,
	input  txCmdPkg::controlCommT                   controlComm,
	input  logic [AddrWidth-1:0]                    programStartAddr,
	input  txCmdPkg::instrWordT                     instrWord,
	input  txChanPkg::phaseDelayT [NumChannels-1:0] phaseDelays,
	input  logic [NumChannels-1:0]                  channelMask,
	input  logic                                    externalTrig,
	input  logic                                    adcTriggerAck,
	input  logic [7:0]                              ledReg,
	input  logic [7:0]                              trigReg,
	input  logic [7:0]                              trigRestLevelReg,
	output logic [AddrWidth-1:0]                    instrReadAddr,
	output logic [NumChannels-1:0]                  transducerOut,
	output logic [NumChannels-1:0]                  transducerError,
	output logic [7:0]                              triggerOut,
	output logic [7:0]                              ledOut,
	output logic                                    adcTriggerLine
);

	logic runEnable;
	logic loadEnable;
	logic clearFault;
	logic channelFault;

	logic                   instrStrobe;
	txCmdPkg::instrTypeT    currentType;
	txCmdPkg::instrPayloadU currentPayload;

	logic                  trigSetStrobe;
	logic [6:0]            trigSetValue;
	logic                  ledSetStrobe;
	logic [7:0]            ledSetValue;
	logic                  fireStrobe;
	txChanPkg::chargeTimeT fireChargeTime;

	txModeControl modeControl_i (
		.txCLK           (txCLK),
		.rst             (rst),
		.controlComm     (controlComm),
		.ledReg          (ledReg),
		.trigReg         (trigReg),
		.trigRestLevelReg(trigRestLevelReg),
		.trigSetStrobe   (trigSetStrobe),
		.trigSetValue    (trigSetValue),
		.ledSetStrobe    (ledSetStrobe),
		.ledSetValue     (ledSetValue),
		.channelFault    (channelFault),
		.runEnable       (runEnable),
		.loadEnable      (loadEnable),
		.clearFault      (clearFault),
		.triggerOut      (triggerOut),
		.ledOut          (ledOut)
	);

	instrFetch #(
		.AddrWidth(AddrWidth)
	) fetch_i (
		.txCLK           (txCLK),
		.rst             (rst),
		.runEnable       (runEnable),
		.loadEnable      (loadEnable),
		.programStartAddr(programStartAddr),
		.instrWord       (instrWord),
		.externalTrig    (externalTrig),
		.instrReadAddr   (instrReadAddr),
		.instrStrobe     (instrStrobe),
		.currentType     (currentType),
		.currentPayload  (currentPayload)
	);

	instrExecute execute_i (
		.txCLK         (txCLK),
		.rst           (rst),
		.runEnable     (runEnable),
		.instrStrobe   (instrStrobe),
		.currentType   (currentType),
		.currentPayload(currentPayload),
		.adcTriggerAck (adcTriggerAck),
		.trigSetStrobe (trigSetStrobe),
		.trigSetValue  (trigSetValue),
		.ledSetStrobe  (ledSetStrobe),
		.ledSetValue   (ledSetValue),
		.fireStrobe    (fireStrobe),
		.fireChargeTime(fireChargeTime),
		.adcTriggerLine(adcTriggerLine)
	);

	fireControl #(
		.NumChannels  (NumChannels),
		.MaxPhaseDelay(MaxPhaseDelay)
	) fire_i (
		.txCLK          (txCLK),
		.rst            (rst),
		.runEnable      (runEnable),
		.clearFault     (clearFault),
		.fireStrobe     (fireStrobe),
		.fireChargeTime (fireChargeTime),
		.phaseDelays    (phaseDelays),
		.channelMask    (channelMask),
		.transducerOut  (transducerOut),
		.transducerError(transducerError),
		.channelFault   (channelFault)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
	--top-module txSequencerTb -f sources.f

output=$(./obj_dir/VtxSequencerTb)
echo "$output"

if grep -q "Testbench passed" <<< "$output"
then
	exit 0
fi
exit 1

//--- sources.f
+incdir+test
design/txCmdPkg.sv
design/txChanPkg.sv
design/channelPulser.sv
design/fireControl.sv
design/instrExecute.sv
design/instrFetch.sv
design/txModeControl.sv
design/txSequencerTop.sv
test/txSequencerTb.sv

//--- test/txTestTasks.svh
`ifndef TX_TEST_TASKS_SVH
`define TX_TEST_TASKS_SVH

task automatic waitForAddr(input int addr, input int limit);
	int n;
	n = 0;
	while (instrReadAddr != AddrWidth'(addr) && n < limit)
	begin
		@(negedge txCLK);
		n++;
	end
	if (instrReadAddr != AddrWidth'(addr))
		reportProblem($sformatf("read address never reached %0d", addr));
endtask

task automatic waitForOutput(input bit onTrigger, input logic [7:0] value, input int limit);
	int n;
	logic [7:0] seen;
	n = 0;
	seen = onTrigger ? triggerOut : ledOut;
	while (seen !== value && n < limit)
	begin
		@(negedge txCLK);
		seen = onTrigger ? triggerOut : ledOut;
		n++;
	end
	if (seen !== value)
		reportProblem($sformatf("%s never showed %h", onTrigger ? "triggerOut" : "ledOut", value));
endtask

task automatic waitForAdcLine(input logic level, input int limit);
	int n;
	n = 0;
	while (adcTriggerLine !== level && n < limit)
	begin
		@(negedge txCLK);
		n++;
	end
	if (adcTriggerLine !== level)
		reportProblem($sformatf("adcTriggerLine did not go to %0d", level));
endtask

task automatic setRestLevel(input logic [7:0] level);
	@(posedge txCLK);
	trigRestLevelReg <= level;
	controlComm <= txCmdPkg::SetTrigRestLevel;
	repeat (2) @(negedge txCLK);
	issueCommand(txCmdPkg::SoftReset, 2);
endtask

task automatic loadAndRun();
	issueCommand(txCmdPkg::LoadProgram, 3);
	issueCommand(txCmdPkg::RunProgram, 1);
endtask

task automatic stopProgram();
	issueCommand(txCmdPkg::SoftReset, 3);
endtask

// record rise, length and span of every channel for one fire
task automatic measureFire(input int chargeTime);
	int riseAt [NumChannels];
	int highCnt [NumChannels];
	int lastHigh [NumChannels];
	int cyc;
	logic done;
	for (int ch = 0; ch < NumChannels; ch++)
	begin
		riseAt[ch] = -1;
		highCnt[ch] = 0;
		lastHigh[ch] = -1;
	end
	cyc = 0;
	done = 1'b0;
	while (!done && cyc < 2500)
	begin
		@(negedge txCLK);
		done = 1'b1;
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			if (transducerOut[ch])
			begin
				if (riseAt[ch] < 0)
					riseAt[ch] = cyc;
				highCnt[ch]++;
				lastHigh[ch] = cyc;
			end
			if (channelMask[ch] && (riseAt[ch] < 0 || transducerOut[ch]))
				done = 1'b0; // unmasked channel not finished yet
		end
		cyc++;
	end
	if (!done)
		reportProblem("fire pulses did not finish in time");
	for (int ch = 0; ch < NumChannels; ch++)
	begin
		if (channelMask[ch])
		begin
			compareValue($sformatf("transducerOut[%0d] high cycles", ch),
				32'(highCnt[ch]), 32'(chargeTime));
			compareValue($sformatf("transducerOut[%0d] span", ch),
				32'(lastHigh[ch] - riseAt[ch] + 1), 32'(chargeTime));
			compareValue($sformatf("transducerOut[%0d] offset", ch),
				32'(riseAt[ch] - riseAt[0]),
				32'(int'(phaseDelays[ch]) - int'(phaseDelays[0])));
		end
		else
			compareValue($sformatf("transducerOut[%0d] masked", ch), 32'(highCnt[ch]), 32'd0);
	end
endtask

task automatic manualModes();
	int errs;
	logic [7:0] led;
	logic [7:0] rest;
	logic [7:0] trig;
	errs = errorCount;
	led = 8'(randBits(8));
	rest = 8'(randBits(8));
	trig = 8'(randBits(8));
	compareValue("instrReadAddr", 32'(instrReadAddr), 32'd0); // state out of reset
	compareValue("transducerOut", 32'(transducerOut), 32'd0);
	compareValue("transducerError", 32'(transducerError), 32'd0);
	compareValue("triggerOut", 32'(triggerOut), 32'd0);
	compareValue("ledOut", 32'(ledOut), 32'd0);
	compareValue("adcTriggerLine", 32'(adcTriggerLine), 32'd0);
	@(posedge txCLK);
	ledReg <= led;
	trigReg <= trig;
	trigRestLevelReg <= rest;
	issueCommand(txCmdPkg::SetLedOutput, 2);
	compareValue("ledOut", 32'(ledOut), 32'(led));
	issueCommand(txCmdPkg::SetTrigRestLevel, 2);
	issueCommand(txCmdPkg::TestTrigOutput, 2);
	compareValue("triggerOut", 32'(triggerOut), 32'(trig ^ rest));
	issueCommand(txCmdPkg::SoftReset, 2);
	compareValue("triggerOut", 32'(triggerOut), 32'(rest));
	compareValue("ledOut", 32'(ledOut), 32'd0);
	issueCommand(txCmdPkg::HardReset, 2);
	compareValue("triggerOut", 32'(triggerOut), 32'd0);
	testDone("manual modes", errs);
endtask

task automatic programOutputs();
	int errs;
	int op;
	logic [7:0] rest;
	logic [7:0] vals [6];
	errs = errorCount;
	rest = 8'(randBits(8));
	setRestLevel(rest);
	for (int i = 0; i < 6; i++)
	begin
		vals[i] = 8'(randBits(8));
		op = (i % 2 == 0) ? txCmdPkg::OpSetLeds : txCmdPkg::OpSetTrig;
		// at least 3 cycles apart so every address is seen
		instrMem[i] = makeInstr(opBit(op), payloadFor(op, {1'b0, vals[i]}), 32'd3 + randBits(3));
	end
	instrMem[6] = makeInstr(opBit(txCmdPkg::OpProgramEnd), '0, 32'd0);
	loadAndRun();
	for (int i = 0; i < 6; i++)
	begin
		waitForAddr(i + 1, 100);
		repeat (2) @(negedge txCLK); // strobe, then output register
		if (i % 2 == 0)
			compareValue("ledOut", 32'(ledOut), 32'(vals[i]));
		else
			compareValue("triggerOut", 32'(triggerOut), 32'({1'b0, vals[i][6:0]} ^ rest));
	end
	stopProgram();
	testDone("program outputs", errs);
endtask

task automatic waitAndAdcTrigger();
	int errs;
	logic [7:0] led1;
	logic [7:0] led2;
	errs = errorCount;
	led1 = 8'(randBits(8));
	led2 = led1 ^ (8'(randBits(8)) | 8'h01);
	instrMem[0] = makeInstr(opBit(txCmdPkg::OpSetLeds),
		payloadFor(txCmdPkg::OpSetLeds, {1'b0, led1}), 32'd2);
	instrMem[1] = makeInstr(opBit(txCmdPkg::OpWaitExternal), '0, 32'd0);
	instrMem[2] = makeInstr(opBit(txCmdPkg::OpSetLeds),
		payloadFor(txCmdPkg::OpSetLeds, {1'b0, led2}), 32'd2);
	instrMem[3] = makeInstr(opBit(txCmdPkg::OpTriggerRecv), '0, 32'd2);
	instrMem[4] = makeInstr(opBit(txCmdPkg::OpProgramEnd), '0, 32'd0);
	loadAndRun();
	waitForOutput(1'b0, led1, 50);
	repeat (30) @(negedge txCLK);
	compareValue("ledOut", 32'(ledOut), 32'(led1)); // held by the wait
	compareValue("instrReadAddr", 32'(instrReadAddr), 32'd2);
	@(posedge txCLK);
	externalTrig <= 1'b1;
	waitForOutput(1'b0, led2, 50);
	waitForAdcLine(1'b1, 50);
	repeat (10) @(negedge txCLK);
	compareValue("adcTriggerLine", 32'(adcTriggerLine), 32'd1); // no ack yet
	@(posedge txCLK);
	adcTriggerAck <= 1'b1;
	waitForAdcLine(1'b0, 10);
	@(posedge txCLK);
	adcTriggerAck <= 1'b0;
	externalTrig <= 1'b0;
	stopProgram();
	testDone("wait and ADC trigger", errs);
endtask

task automatic fireTiming();
	int errs;
	logic [8:0] ct;
	errs = errorCount;
	ct = 9'd8 + 9'(randBits(5));
	@(posedge txCLK);
	for (int ch = 0; ch < NumChannels; ch++)
		phaseDelays[ch] <= 16'(randBits(8));
	channelMask <= (8'(randBits(8)) | 8'h03) & 8'h7f; // channel 7 always masked
	// second fire waits until the first has fully ended
	instrMem[0] = makeInstr(opBit(txCmdPkg::OpFire) | opBit(txCmdPkg::OpSetChargeTime),
		payloadFor(txCmdPkg::OpSetChargeTime, ct), 32'd600);
	instrMem[1] = makeInstr(opBit(txCmdPkg::OpFire), '0, 32'd0);
	instrMem[2] = makeInstr(opBit(txCmdPkg::OpProgramEnd), '0, 32'd0);
	loadAndRun();
	measureFire(int'(ct));
	measureFire(500);
	stopProgram();
	testDone("fire timing", errs);
endtask

task automatic faultRecovery();
	int errs;
	int n;
	logic [7:0] rest;
	logic [7:0] led;
	logic [6:0] trig;
	logic [2:0] bad;
	errs = errorCount;
	rest = 8'(randBits(8));
	led = 8'(randBits(8)) | 8'h01;
	trig = 7'(randBits(7)) | 7'h01;
	bad = 3'(randBits(3));
	setRestLevel(rest);
	@(posedge txCLK);
	for (int ch = 0; ch < NumChannels; ch++)
		phaseDelays[ch] <= (ch == int'(bad)) ? 16'd1500 : 16'(randBits(8));
	channelMask <= 8'hff;
	instrMem[0] = makeInstr(opBit(txCmdPkg::OpSetLeds),
		payloadFor(txCmdPkg::OpSetLeds, {1'b0, led}), 32'd4);
	instrMem[1] = makeInstr(opBit(txCmdPkg::OpSetTrig),
		payloadFor(txCmdPkg::OpSetTrig, {2'b0, trig}), 32'd4);
	instrMem[2] = makeInstr(opBit(txCmdPkg::OpFire), '0, 32'd50);
	instrMem[3] = makeInstr(opBit(txCmdPkg::OpProgramEnd), '0, 32'd0);
	loadAndRun();
	waitForOutput(1'b0, led, 50);
	waitForOutput(1'b1, {1'b0, trig} ^ rest, 50);
	n = 0;
	while (transducerError == '0 && n < 50)
	begin
		@(negedge txCLK);
		n++;
	end
	if (transducerError == '0)
		reportProblem("no channel error after an out of range phase delay");
	repeat (3) @(negedge txCLK);
	compareValue("transducerError", 32'(transducerError), 32'(8'h01 << bad));
	compareValue("transducerOut", 32'(transducerOut), 32'd0);
	compareValue("ledOut", 32'(ledOut), 32'd0);
	compareValue("triggerOut", 32'(triggerOut), 32'(rest));
	issueCommand(txCmdPkg::SoftReset, 3);
	compareValue("transducerError", 32'(transducerError), 32'd0);
	testDone("fault recovery", errs);
endtask

task automatic programEndHold();
	int errs;
	logic [7:0] led;
	logic stable;
	errs = errorCount;
	led = 8'(randBits(8));
	instrMem[0] = makeInstr(opBit(txCmdPkg::OpSetLeds),
		payloadFor(txCmdPkg::OpSetLeds, {1'b0, led}), 32'd3);
	instrMem[1] = makeInstr(opBit(txCmdPkg::OpProgramEnd), '0, 32'd0);
	loadAndRun();
	waitForAddr(2, 50);
	waitForOutput(1'b0, led, 10);
	stable = 1'b1;
	for (int n = 0; n < 200; n++)
	begin
		@(negedge txCLK);
		if (instrReadAddr != AddrWidth'(2) || ledOut !== led)
			stable = 1'b0;
	end
	compareValue("instrReadAddr", 32'(instrReadAddr), 32'd2);
	compareValue("ledOut", 32'(ledOut), 32'(led));
	if (!stable)
		reportProblem("read address or LEDs changed after program end");
	stopProgram();
	testDone("program end", errs);
endtask

`endif

//--- test/txSequencerTb.sv
module txSequencerTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumChannels = 8;
	localparam int MaxPhaseDelay = 1000;
	localparam int AddrWidth = 13;

	logic txCLK;
	logic rst;
	txCmdPkg::controlCommT controlComm;
	logic [AddrWidth-1:0] programStartAddr;
	txCmdPkg::instrWordT instrWord;
	txChanPkg::phaseDelayT [NumChannels-1:0] phaseDelays;
	logic [NumChannels-1:0] channelMask;
	logic externalTrig;
	logic adcTriggerAck;
	logic [7:0] ledReg;
	logic [7:0] trigReg;
	logic [7:0] trigRestLevelReg;
	logic [AddrWidth-1:0] instrReadAddr;
	logic [NumChannels-1:0] transducerOut;
	logic [NumChannels-1:0] transducerError;
	logic [7:0] triggerOut;
	logic [7:0] ledOut;
	logic adcTriggerLine;

	txCmdPkg::instrWordT instrMem [256]; // external instruction memory
	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int testCount;

	assign instrWord = instrMem[instrReadAddr[7:0]]; // combinational read

	txSequencerTop #(
		.NumChannels  (NumChannels),
		.MaxPhaseDelay(MaxPhaseDelay),
		.AddrWidth    (AddrWidth)
	) dut_i (
		.txCLK           (txCLK),
		.rst             (rst),
		.controlComm     (controlComm),
		.programStartAddr(programStartAddr),
		.instrWord       (instrWord),
		.phaseDelays     (phaseDelays),
		.channelMask     (channelMask),
		.externalTrig    (externalTrig),
		.adcTriggerAck   (adcTriggerAck),
		.ledReg          (ledReg),
		.trigReg         (trigReg),
		.trigRestLevelReg(trigRestLevelReg),
		.instrReadAddr   (instrReadAddr),
		.transducerOut   (transducerOut),
		.transducerError (transducerError),
		.triggerOut      (triggerOut),
		.ledOut          (ledOut),
		.adcTriggerLine  (adcTriggerLine)
	);

	initial
	begin
		txCLK = 1'b0;
		forever #2 txCLK = ~txCLK;
	end

	// one Galois step, returns the bit shifted out
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'h80200003;
		return outBit;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
			value = {value[30:0], lfsrBit()};
		return value;
	endfunction

	function automatic txCmdPkg::instrTypeT opBit(input int op);
		return 16'h0001 << op;
	endfunction

	// payload view chosen by the opcode it goes with
	function automatic txCmdPkg::instrPayloadU payloadFor(input int op, input logic [8:0] value);
		txCmdPkg::instrPayloadU p;
		p = '0;
		if (op == txCmdPkg::OpSetTrig)
			p.trig.trigVals = value[6:0];
		else if (op == txCmdPkg::OpSetLeds)
			p.led.ledVals = value[7:0];
		else
			p.charge.chargeTime = value;
		return p;
	endfunction

	function automatic txCmdPkg::instrWordT makeInstr(input txCmdPkg::instrTypeT instrType,
		input txCmdPkg::instrPayloadU payload, input logic [31:0] delay);
		txCmdPkg::instrWordT word;
		word.instrType = instrType;
		word.payload = payload;
		word.delay = delay;
		return word;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("ERROR %s", msg);
	endtask

	task automatic testDone(input string name, input int errsBefore);
		testCount++;
		if (errorCount == errsBefore)
			$display("test %s ok", name);
		else
			$display("test %s had %0d errors", name, errorCount - errsBefore);
	endtask

	// drive on the rising edge, return on a falling edge
	task automatic issueCommand(input txCmdPkg::controlCommT c, input int settleCycles);
		@(posedge txCLK);
		controlComm <= c;
		repeat (settleCycles) @(negedge txCLK);
	endtask

	`include "txTestTasks.svh"

	initial
	begin
		lfsrState = 32'h3a5abbe2;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		rst <= 1'b1;
		controlComm <= txCmdPkg::HardReset;
		programStartAddr <= '0;
		phaseDelays <= '0;
		channelMask <= '0;
		externalTrig <= 1'b0;
		adcTriggerAck <= 1'b0;
		ledReg <= '0;
		trigReg <= '0;
		trigRestLevelReg <= '0;
		// unused words end the program, delay follows the address
		for (int a = 0; a < 256; a++)
			instrMem[a] = makeInstr(opBit(txCmdPkg::OpProgramEnd), '0, 32'(a));
		repeat (5) @(posedge txCLK);
		rst <= 1'b0;
		@(negedge txCLK);
		manualModes();
		programOutputs();
		waitAndAdcTrigger();
		fireTiming();
		faultRecovery();
		programEndHold();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
